/* list.f */
+incdir+common
common/mini_mcu_pkg.sv
system_bus/bus_arbiter.sv
system_bus/system_bus.sv
memory_subsystem/memory_subsystem.sv
peripheral_subsystem/gpio_regs.sv
peripheral_subsystem/peripheral_subsystem.sv
src/mini_mcu_top.sv
sim/bus_checker.sv
sim/tb_mini_mcu.sv

/* sim/tb_mini_mcu.sv */
////////////////////
// testbench: clock, reset, random and directed
// traffic on both masters, run timeout
////////////////////
`timescale 1ns/100ps
`include "mini_mcu_cfg.svh"

module tb_mini_mcu
  import mini_mcu_pkg::*;
();

  localparam logic [31:0] SEED = 32'h3507_ce3c;
  localparam int N_RANDOM     = 1500;
  localparam int N_CONTINUOUS = 200;
  // roughly twice the cycles the three phases need
  localparam int TIMEOUT = 2 * (2 * N_RANDOM + N_CONTINUOUS + 800);

  logic                 clk_i;
  logic                 reset_i;
  logic      [1:0]      req;
  logic      [1:0]      we;
  bus_be_t   [1:0]      be;
  bus_addr_t [1:0]      addr;
  bus_data_t [1:0]      wdata;
  wire       [1:0]      gnt;
  wire       [1:0]      rvalid;
  wire       [1:0]      err;
  wire       [1:0][31:0] rdata;
  bus_data_t            gpio_in;
  wire       [31:0]     gpio_out;
  wire       [31:0]     gpio_en;
  wire       [31:0]     exit_value;
  wire                  exit_valid;

  logic [31:0] rng;
  logic [31:0] gpio_rng;
  int          cycle_count;
  int          granted [2];

  mini_mcu_top DUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .m0_req_i     (req[0]),
    .m0_we_i      (we[0]),
    .m0_be_i      (be[0]),
    .m0_addr_i    (addr[0]),
    .m0_wdata_i   (wdata[0]),
    .m0_gnt_o     (gnt[0]),
    .m0_rvalid_o  (rvalid[0]),
    .m0_rdata_o   (rdata[0]),
    .m0_err_o     (err[0]),
    .m1_req_i     (req[1]),
    .m1_we_i      (we[1]),
    .m1_be_i      (be[1]),
    .m1_addr_i    (addr[1]),
    .m1_wdata_i   (wdata[1]),
    .m1_gnt_o     (gnt[1]),
    .m1_rvalid_o  (rvalid[1]),
    .m1_rdata_o   (rdata[1]),
    .m1_err_o     (err[1]),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_en_o    (gpio_en),
    .exit_value_o (exit_value),
    .exit_valid_o (exit_valid)
  );

  bus_checker bus_checker_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req),
    .we_i         (we),
    .be_i         (be),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .gnt_i        (gnt),
    .rvalid_i     (rvalid),
    .rdata_i      (rdata),
    .err_i        (err),
    .gpio_in_i    (gpio_in),
    .gpio_out_i   (gpio_out),
    .gpio_en_i    (gpio_en),
    .exit_value_i (exit_value),
    .exit_valid_i (exit_valid)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // soc ctrl, gpio and a few holes in peripheral space
  function automatic bus_addr_t periph_offset(input logic [2:0] k);
    case (k)
      3'd0:    return `SOC_CTRL_OFFSET;
      3'd1:    return `SOC_CTRL_OFFSET + 32'h4;
      3'd2:    return `SOC_CTRL_OFFSET + 32'h8;
      3'd3:    return `GPIO_OFFSET;
      3'd4:    return `GPIO_OFFSET + 32'h4;
      3'd5:    return `GPIO_OFFSET + 32'h8;
      3'd6:    return `GPIO_OFFSET + 32'hc;
      default: return 32'h0000_1800;
    endcase
  endfunction

  task automatic draw_request(input int m);
    logic [31:0] r;
    logic [31:0] d;
    bus_addr_t   a;
    bus_be_t     b;
    rng = xorshift(rng);
    r = rng;
    rng = xorshift(rng);
    d = rng;
    b = r[7:4];
    case (r[10:8])
      3'd0, 3'd1, 3'd2: a = `RAM0_BASE + {r[19:12], 2'b00};
      3'd3, 3'd4, 3'd5: a = `RAM1_BASE + {r[19:12], 2'b00};
      3'd6: begin
        a = `PERIPH_BASE + periph_offset(r[14:12]);
        b = 4'hf;
      end
      default: begin
        // unmapped, just above ram or far away
        if (r[11]) begin
          a = 32'h0000_0800 + {r[20:12], 2'b00};
        end else begin
          a = 32'h4000_0000 + {r[31:12], 2'b00};
        end
      end
    endcase
    req[m]   <= 1'b1;
    we[m]    <= r[0];
    be[m]    <= b;
    addr[m]  <= a;
    wdata[m] <= d;
  endtask

  task automatic issue_access(input logic wr, input bus_addr_t a, input bus_data_t d);
    req[0]   <= 1'b1;
    we[0]    <= wr;
    be[0]    <= 4'hf;
    addr[0]  <= a;
    wdata[0] <= d;
    @(posedge clk_i);
    while (!gnt[0]) begin
      @(posedge clk_i);
    end
    req[0] <= 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    gpio_rng = xorshift(gpio_rng);
    gpio_in <= gpio_rng;
  end

  initial begin
    while (cycle_count < TIMEOUT) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: run still busy after %0d cycles", TIMEOUT);
    $display("checks %0d, errors %0d", bus_checker_i.checks, bus_checker_i.errors);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic drained;
    reset_i = 1'b1;
    req = '0;
    we = '0;
    be = '0;
    addr = '0;
    wdata = '0;
    gpio_in = '0;
    rng = SEED;
    gpio_rng = xorshift(~SEED);
    cycle_count = 0;
    granted[0] = 0;
    granted[1] = 0;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    // random traffic with idle gaps
    while (granted[0] < N_RANDOM || granted[1] < N_RANDOM) begin
      @(posedge clk_i);
      for (int m = 0; m < 2; m++) begin
        if (gnt[m]) begin
          granted[m]++;
        end
        if (!req[m] || gnt[m]) begin
          rng = xorshift(rng);
          if (granted[m] < N_RANDOM && rng[1:0] != 2'b00) begin
            draw_request(m);
          end else begin
            req[m] <= 1'b0;
          end
        end
      end
    end

    // both masters keep requesting
    repeat (N_CONTINUOUS) begin
      @(posedge clk_i);
      for (int m = 0; m < 2; m++) begin
        if (!req[m] || gnt[m]) begin
          draw_request(m);
        end
      end
    end
    drained = 1'b0;
    while (!drained) begin
      @(posedge clk_i);
      drained = 1'b1;
      for (int m = 0; m < 2; m++) begin
        if (req[m] && !gnt[m]) begin
          drained = 1'b0;
        end else begin
          req[m] <= 1'b0;
        end
      end
    end

    // exit value, then exit valid, then read both back
    issue_access(1'b1, `PERIPH_BASE + `SOC_CTRL_OFFSET + 32'h4, 32'h0000_00a5);
    issue_access(1'b1, `PERIPH_BASE + `SOC_CTRL_OFFSET, 32'h0000_0001);
    issue_access(1'b0, `PERIPH_BASE + `SOC_CTRL_OFFSET + 32'h4, '0);
    issue_access(1'b0, `PERIPH_BASE + `SOC_CTRL_OFFSET, '0);
    repeat (3) @(posedge clk_i);

    $display("checks %0d, errors %0d", bus_checker_i.checks, bus_checker_i.errors);
    if (bus_checker_i.errors == 0 && bus_checker_i.checks > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* sim/bus_checker.sv */
////////////////////
// bus monitor with ram and register model,
// compares responses and status outputs
////////////////////
`timescale 1ns/100ps
`include "mini_mcu_cfg.svh"

module bus_checker
  import mini_mcu_pkg::*;
(
  input logic            clk_i,
  input logic            reset_i,
  input logic      [1:0] req_i,
  input logic      [1:0] we_i,
  input bus_be_t   [1:0] be_i,
  input bus_addr_t [1:0] addr_i,
  input bus_data_t [1:0] wdata_i,
  input logic      [1:0] gnt_i,
  input logic      [1:0] rvalid_i,
  input bus_data_t [1:0] rdata_i,
  input logic      [1:0] err_i,
  input bus_data_t       gpio_in_i,
  input bus_data_t       gpio_out_i,
  input bus_data_t       gpio_en_i,
  input bus_data_t       exit_value_i,
  input logic            exit_valid_i
);

  localparam bus_addr_t RAM_BYTES = `RAM_WORDS * 4;

  int errors;
  int checks;

  bus_data_t  ram [2][`RAM_WORDS];
  // bytes of each word written so far
  logic [3:0] known [2][`RAM_WORDS];

  bus_data_t exit_value_m;
  logic      exit_valid_m;
  bus_data_t gpio_out_m;
  bus_data_t gpio_en_m;
  bus_data_t sync1_m;
  bus_data_t sync2_m;
  logic      last1_m;
  logic      rst_q;

  // response expected in the next cycle
  logic      pend;
  logic      pend_m;
  bus_data_t pend_rdata;
  bus_data_t pend_mask;
  logic      pend_err;
  string     pend_name;

  initial begin
    errors = 0;
    checks = 0;
    rst_q = 1'b0;
    pend = 1'b0;
    for (int k = 0; k < `RAM_WORDS; k++) begin
      known[0][k] = '0;
      known[1][k] = '0;
    end
  end

  task automatic compare(input string name, input bus_data_t exp, input bus_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("%0t: %s", $time, what);
  endtask

  function automatic logic in_range(input bus_addr_t a, input bus_addr_t base,
                                    input bus_addr_t size);
    bus_addr_t off;
    off = a - base;
    return off < size;
  endfunction

  task automatic reset_model();
    exit_value_m = '0;
    exit_valid_m = 1'b0;
    gpio_out_m = '0;
    gpio_en_m = '0;
    sync1_m = '0;
    sync2_m = '0;
    last1_m = 1'b1;
    pend = 1'b0;
  endtask

  task automatic idle_after_reset();
    checks++;
    if ((gnt_i | rvalid_i | err_i) !== 2'b00 || exit_valid_i !== 1'b0 ||
        gpio_en_i !== '0 || gpio_out_i !== '0 || exit_value_i !== '0) begin
      report("outputs not in their reset state during or right after reset");
    end
  endtask

  task automatic compare_outputs();
    compare("exit_value_o", exit_value_m, exit_value_i);
    compare("exit_valid_o", 32'(exit_valid_m), 32'(exit_valid_i));
    compare("gpio_o", gpio_out_m, gpio_out_i);
    compare("gpio_en_o", gpio_en_m, gpio_en_i);
  endtask

  task automatic match_response();
    if (!pend) begin
      if (rvalid_i !== 2'b00 || err_i !== 2'b00) begin
        report("rvalid or err high with no grant in the cycle before");
      end
    end else if (rvalid_i[pend_m] !== 1'b1 || rvalid_i[!pend_m] !== 1'b0 ||
                 err_i[!pend_m] !== 1'b0) begin
      report($sformatf("response not on m%0d one cycle after its grant", pend_m));
    end else begin
      compare($sformatf("%s m%0d", pend_name, pend_m), pend_rdata,
              rdata_i[pend_m] & pend_mask);
      compare($sformatf("%s err m%0d", pend_name, pend_m), 32'(pend_err),
              32'(err_i[pend_m]));
    end
  endtask

  task automatic periph_access(input bus_addr_t off, input logic w, input bus_data_t d);
    if (w) begin
      pend_name = "periph write";
    end else begin
      pend_name = "periph read";
    end
    case ({off[31:2], 2'b00})
      `SOC_CTRL_OFFSET: begin
        if (w) exit_valid_m = d[0];
        else pend_rdata = 32'(exit_valid_m);
      end
      `SOC_CTRL_OFFSET + 32'h4: begin
        if (w) exit_value_m = d;
        else pend_rdata = exit_value_m;
      end
      `GPIO_OFFSET: begin
        if (w) gpio_out_m = d;
        else pend_rdata = gpio_out_m;
      end
      `GPIO_OFFSET + 32'h4: begin
        if (w) gpio_en_m = d;
        else pend_rdata = gpio_en_m;
      end
      `GPIO_OFFSET + 32'h8: begin
        if (!w) pend_rdata = sync2_m;
      end
      default: ;
    endcase
  endtask

  task automatic apply_access(input logic m);
    bus_addr_t a;
    bus_data_t d;
    bus_be_t   b;
    logic      w;
    int        bank;
    bus_addr_t off;
    ram_idx_t  idx;
    a = addr_i[m];
    d = wdata_i[m];
    b = be_i[m];
    w = we_i[m];
    pend_rdata = '0;
    pend_mask = '1;
    pend_err = 1'b0;
    if (in_range(a, `RAM0_BASE, RAM_BYTES) || in_range(a, `RAM1_BASE, RAM_BYTES)) begin
      bank = in_range(a, `RAM1_BASE, RAM_BYTES) ? 1 : 0;
      off = a - ((bank == 1) ? `RAM1_BASE : `RAM0_BASE);
      idx = ram_idx_t'(off >> 2);
      if (w) begin
        pend_name = "ram write";
        for (int i = 0; i < 4; i++) begin
          if (b[i]) begin
            ram[bank][idx][8*i +: 8] = d[8*i +: 8];
            known[bank][idx][i] = 1'b1;
          end
        end
      end else begin
        pend_name = "ram read";
        for (int i = 0; i < 4; i++) begin
          pend_mask[8*i +: 8] = {8{known[bank][idx][i]}};
        end
        pend_rdata = ram[bank][idx] & pend_mask;
      end
    end else if (in_range(a, `PERIPH_BASE, `PERIPH_SIZE)) begin
      periph_access(a - `PERIPH_BASE, w, d);
    end else begin
      pend_err = 1'b1;
      if (w) begin
        pend_name = "bus error write";
      end else begin
        pend_name = "bus error read";
        pend_rdata = `BUS_ERR_RDATA;
      end
    end
  endtask

  task automatic verify_grant();
    logic [1:0] exp_gnt;
    // tie goes to the master not granted last
    if (req_i == 2'b11) begin
      exp_gnt = last1_m ? 2'b01 : 2'b10;
    end else begin
      exp_gnt = req_i;
    end
    pend = 1'b0;
    if (gnt_i === 2'b11) begin
      report("both masters granted in one cycle");
    end else begin
      compare("grant", 32'(exp_gnt), 32'(gnt_i));
      if (gnt_i === 2'b01 || gnt_i === 2'b10) begin
        last1_m = gnt_i[1];
        pend_m = gnt_i[1];
        pend = 1'b1;
        apply_access(gnt_i[1]);
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      if (rst_q) begin
        idle_after_reset();
      end
      reset_model();
      rst_q = 1'b1;
    end else begin
      if (rst_q) begin
        idle_after_reset();
      end
      rst_q = 1'b0;
      compare_outputs();
      match_response();
      verify_grant();
      // mirror of the gpio_i synchronizer
      sync2_m = sync1_m;
      sync1_m = gpio_in_i;
    end
  end

endmodule

/* src/mini_mcu_top.sv */
////////////////////
// top level: system bus, memory and
// peripheral subsystems
////////////////////
`timescale 1ns/100ps

module mini_mcu_top
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      m0_req_i,
  input  logic      m0_we_i,
  input  bus_be_t   m0_be_i,
  input  bus_addr_t m0_addr_i,
  input  bus_data_t m0_wdata_i,
  output logic      m0_gnt_o,
  output logic      m0_rvalid_o,
  output bus_data_t m0_rdata_o,
  output logic      m0_err_o,

  input  logic      m1_req_i,
  input  logic      m1_we_i,
  input  bus_be_t   m1_be_i,
  input  bus_addr_t m1_addr_i,
  input  bus_data_t m1_wdata_i,
  output logic      m1_gnt_o,
  output logic      m1_rvalid_o,
  output bus_data_t m1_rdata_o,
  output logic      m1_err_o,

  input  bus_data_t gpio_i,
  output bus_data_t gpio_o,
  output bus_data_t gpio_en_o,

  output bus_data_t exit_value_o,
  output logic      exit_valid_o
);

  // shared request path
  logic      bus_we;
  bus_be_t   bus_be;
  bus_addr_t bus_addr;
  bus_data_t bus_wdata;

  logic      ram0_req;
  logic      ram1_req;
  logic      periph_req;

  bus_data_t ram0_rdata;
  bus_data_t ram1_rdata;
  bus_data_t periph_rdata;

  system_bus system_bus_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .m0_req_i       (m0_req_i),
    .m0_we_i        (m0_we_i),
    .m0_be_i        (m0_be_i),
    .m0_addr_i      (m0_addr_i),
    .m0_wdata_i     (m0_wdata_i),
    .m0_gnt_o       (m0_gnt_o),
    .m0_rvalid_o    (m0_rvalid_o),
    .m0_rdata_o     (m0_rdata_o),
    .m0_err_o       (m0_err_o),
    .m1_req_i       (m1_req_i),
    .m1_we_i        (m1_we_i),
    .m1_be_i        (m1_be_i),
    .m1_addr_i      (m1_addr_i),
    .m1_wdata_i     (m1_wdata_i),
    .m1_gnt_o       (m1_gnt_o),
    .m1_rvalid_o    (m1_rvalid_o),
    .m1_rdata_o     (m1_rdata_o),
    .m1_err_o       (m1_err_o),
    .bus_we_o       (bus_we),
    .bus_be_o       (bus_be),
    .bus_addr_o     (bus_addr),
    .bus_wdata_o    (bus_wdata),
    .ram0_req_o     (ram0_req),
    .ram1_req_o     (ram1_req),
    .periph_req_o   (periph_req),
    .ram0_rdata_i   (ram0_rdata),
    .ram1_rdata_i   (ram1_rdata),
    .periph_rdata_i (periph_rdata)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .ram0_req_i   (ram0_req),
    .ram1_req_i   (ram1_req),
    .we_i         (bus_we),
    .be_i         (bus_be),
    .addr_i       (bus_addr),
    .wdata_i      (bus_wdata),
    .ram0_rdata_o (ram0_rdata),
    .ram1_rdata_o (ram1_rdata)
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (periph_req),
    .we_i         (bus_we),
    .addr_i       (bus_addr),
    .wdata_i      (bus_wdata),
    .gpio_i       (gpio_i),
    .rdata_o      (periph_rdata),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o),
    .gpio_o       (gpio_o),
    .gpio_en_o    (gpio_en_o)
  );

endmodule

/* peripheral_subsystem/peripheral_subsystem.sv */
////////////////////
// peripheral decode, exit status registers,
// read mux around the gpio block
////////////////////
`timescale 1ns/100ps
`include "mini_mcu_cfg.svh"

module peripheral_subsystem
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      req_i,
  input  logic      we_i,
  input  bus_addr_t addr_i,
  input  bus_data_t wdata_i,
  input  bus_data_t gpio_i,
  output bus_data_t rdata_o,
  output bus_data_t exit_value_o,
  output logic      exit_valid_o,
  output bus_data_t gpio_o,
  output bus_data_t gpio_en_o
);

  localparam int PER_AW = $clog2(`PERIPH_SIZE);
  localparam bus_addr_t SOC_OFF  = `SOC_CTRL_OFFSET;
  localparam bus_addr_t GPIO_OFF = `GPIO_OFFSET;

  logic [PER_AW-1:0] offset;
  logic              soc_hit;
  logic              gpio_hit;
  bus_data_t         gpio_rdata;
  logic              exit_valid_q;
  bus_data_t         exit_value_q;
  bus_data_t         rdata_q;

  assign offset = addr_i[PER_AW-1:0];

  // soc ctrl spans two words, gpio four
  assign soc_hit  = (offset[PER_AW-1:3] == SOC_OFF[PER_AW-1:3]);
  assign gpio_hit = (offset[PER_AW-1:4] == GPIO_OFF[PER_AW-1:4]);

  gpio_regs gpio_regs_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .sel_i      (req_i && gpio_hit),
    .we_i       (we_i),
    .reg_addr_i (offset[3:2]),
    .wdata_i    (wdata_i),
    .gpio_i     (gpio_i),
    .rdata_o    (gpio_rdata),
    .gpio_o     (gpio_o),
    .gpio_en_o  (gpio_en_o)
  );

  // exit_valid at +0, exit_value at +4
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (req_i && we_i && soc_hit) begin
      if (offset[2]) begin
        exit_value_q <= wdata_i;
      end else begin
        exit_valid_q <= wdata_i[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      if (soc_hit) begin
        rdata_q <= offset[2] ? exit_value_q : bus_data_t'(exit_valid_q);
      end else if (gpio_hit) begin
        rdata_q <= gpio_rdata;
      end else begin
        // holes in peripheral space
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o      = rdata_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

/* peripheral_subsystem/gpio_regs.sv */
////////////////////
// gpio out, enable and synchronized input
////////////////////
`timescale 1ns/100ps

module gpio_regs
  import mini_mcu_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       sel_i,
  input  logic       we_i,
  input  logic [1:0] reg_addr_i,
  input  bus_data_t  wdata_i,
  input  bus_data_t  gpio_i,
  output bus_data_t  rdata_o,
  output bus_data_t  gpio_o,
  output bus_data_t  gpio_en_o
);

  bus_data_t out_q;
  bus_data_t en_q;
  bus_data_t sync1_q;
  bus_data_t sync2_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q <= '0;
      en_q  <= '0;
    end else if (sel_i && we_i) begin
      case (reg_addr_i)
        2'd0:    out_q <= wdata_i;
        2'd1:    en_q  <= wdata_i;
        default: ;
      endcase
    end
  end

  // two-flop input synchronizer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
    end
  end

  always_comb begin
    case (reg_addr_i)
      2'd0:    rdata_o = out_q;
      2'd1:    rdata_o = en_q;
      2'd2:    rdata_o = sync2_q;
      default: rdata_o = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = en_q;

endmodule

/* memory_subsystem/memory_subsystem.sv */
////////////////////
// two ram banks, byte-enable writes,
// registered read data
////////////////////
`timescale 1ns/100ps
`include "mini_mcu_cfg.svh"

module memory_subsystem
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      ram0_req_i,
  input  logic      ram1_req_i,
  input  logic      we_i,
  input  bus_be_t   be_i,
  input  bus_addr_t addr_i,
  input  bus_data_t wdata_i,
  output bus_data_t ram0_rdata_o,
  output bus_data_t ram1_rdata_o
);

  localparam int RAM_AW = $clog2(`RAM_WORDS) + 2;

  ram_idx_t   idx;
  logic [1:0] bank_req;

  // word index, byte offset dropped
  assign idx      = addr_i[RAM_AW-1:2];
  assign bank_req = {ram1_req_i, ram0_req_i};

  for (genvar b = 0; b < 2; b++) begin : g_bank
    bus_data_t mem [`RAM_WORDS];
    bus_data_t rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank_req[b] && we_i) begin
        for (int i = 0; i < $bits(bus_be_t); i++) begin
          if (be_i[i]) begin
            mem[idx][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        rdata_q <= '0;
      end else if (bank_req[b] && !we_i) begin
        rdata_q <= mem[idx];
      end
    end
  end

  assign ram0_rdata_o = g_bank[0].rdata_q;
  assign ram1_rdata_o = g_bank[1].rdata_q;

endmodule

/* system_bus/system_bus.sv */
////////////////////
// shared bus: arbitration, address decode,
// slave strobes and response routing
////////////////////
`timescale 1ns/100ps
`include "mini_mcu_cfg.svh"

module system_bus
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      m0_req_i,
  input  logic      m0_we_i,
  input  bus_be_t   m0_be_i,
  input  bus_addr_t m0_addr_i,
  input  bus_data_t m0_wdata_i,
  output logic      m0_gnt_o,
  output logic      m0_rvalid_o,
  output bus_data_t m0_rdata_o,
  output logic      m0_err_o,

  input  logic      m1_req_i,
  input  logic      m1_we_i,
  input  bus_be_t   m1_be_i,
  input  bus_addr_t m1_addr_i,
  input  bus_data_t m1_wdata_i,
  output logic      m1_gnt_o,
  output logic      m1_rvalid_o,
  output bus_data_t m1_rdata_o,
  output logic      m1_err_o,

  output logic      bus_we_o,
  output bus_be_t   bus_be_o,
  output bus_addr_t bus_addr_o,
  output bus_data_t bus_wdata_o,
  output logic      ram0_req_o,
  output logic      ram1_req_o,
  output logic      periph_req_o,
  input  bus_data_t ram0_rdata_i,
  input  bus_data_t ram1_rdata_i,
  input  bus_data_t periph_rdata_i
);

  localparam int RAM_AW = $clog2(`RAM_WORDS) + 2;
  localparam int PER_AW = $clog2(`PERIPH_SIZE);
  localparam bus_addr_t RAM0_BASE = `RAM0_BASE;
  localparam bus_addr_t RAM1_BASE = `RAM1_BASE;
  localparam bus_addr_t PER_BASE  = `PERIPH_BASE;

  logic       gnt0;
  logic       gnt1;
  logic       any_gnt;
  slave_sel_t sel;

  logic       rsp_valid_q;
  logic       rsp_master_q;
  logic       rsp_we_q;
  slave_sel_t rsp_sel_q;
  logic       rsp_err;
  bus_data_t  rsp_rdata;

  bus_arbiter bus_arbiter_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req0_i  (m0_req_i),
    .req1_i  (m1_req_i),
    .gnt0_o  (gnt0),
    .gnt1_o  (gnt1)
  );

  assign m0_gnt_o = gnt0;
  assign m1_gnt_o = gnt1;
  assign any_gnt  = gnt0 | gnt1;

  // granted master drives the shared wires
  assign bus_we_o    = gnt1 ? m1_we_i    : m0_we_i;
  assign bus_be_o    = gnt1 ? m1_be_i    : m0_be_i;
  assign bus_addr_o  = gnt1 ? m1_addr_i  : m0_addr_i;
  assign bus_wdata_o = gnt1 ? m1_wdata_i : m0_wdata_i;

  always_comb begin
    if (bus_addr_o[31:RAM_AW] == RAM0_BASE[31:RAM_AW]) begin
      sel = SEL_RAM0;
    end else if (bus_addr_o[31:RAM_AW] == RAM1_BASE[31:RAM_AW]) begin
      sel = SEL_RAM1;
    end else if (bus_addr_o[31:PER_AW] == PER_BASE[31:PER_AW]) begin
      sel = SEL_PERIPH;
    end else begin
      sel = SEL_NONE;
    end
  end

  // unmapped addresses get no strobe
  assign ram0_req_o   = any_gnt && (sel == SEL_RAM0);
  assign ram1_req_o   = any_gnt && (sel == SEL_RAM1);
  assign periph_req_o = any_gnt && (sel == SEL_PERIPH);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q  <= 1'b0;
      rsp_master_q <= 1'b0;
      rsp_we_q     <= 1'b0;
      rsp_sel_q    <= SEL_NONE;
    end else begin
      rsp_valid_q <= any_gnt;
      if (any_gnt) begin
        rsp_master_q <= gnt1;
        rsp_we_q     <= bus_we_o;
        rsp_sel_q    <= sel;
      end
    end
  end

  assign rsp_err = (rsp_sel_q == SEL_NONE);

  always_comb begin
    case (rsp_sel_q)
      SEL_RAM0:   rsp_rdata = ram0_rdata_i;
      SEL_RAM1:   rsp_rdata = ram1_rdata_i;
      SEL_PERIPH: rsp_rdata = periph_rdata_i;
      default:    rsp_rdata = `BUS_ERR_RDATA;
    endcase
    // writes always return zero
    if (rsp_we_q) begin
      rsp_rdata = '0;
    end
  end

  assign m0_rvalid_o = rsp_valid_q && !rsp_master_q;
  assign m1_rvalid_o = rsp_valid_q && rsp_master_q;
  assign m0_err_o    = rsp_valid_q && !rsp_master_q && rsp_err;
  assign m1_err_o    = rsp_valid_q && rsp_master_q && rsp_err;
  assign m0_rdata_o  = rsp_rdata;
  assign m1_rdata_o  = rsp_rdata;

endmodule

/* system_bus/bus_arbiter.sv */
////////////////////
// round-robin arbiter for two masters
////////////////////
`timescale 1ns/100ps

module bus_arbiter (
  input  logic clk_i,
  input  logic reset_i,
  input  logic req0_i,
  input  logic req1_i,
  output logic gnt0_o,
  output logic gnt1_o
);

  // high when master 1 got the last grant
  logic last1_q;

  // on a tie the master not served last wins
  assign gnt0_o = req0_i && (!req1_i || last1_q);
  assign gnt1_o = req1_i && (!req0_i || !last1_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // so master 0 takes the first tie
      last1_q <= 1'b1;
    end else if (gnt0_o) begin
      last1_q <= 1'b0;
    end else if (gnt1_o) begin
      last1_q <= 1'b1;
    end
  end

endmodule

/* common/mini_mcu_pkg.sv */
////////////////////
// bus and memory types, slave select codes
////////////////////
package mini_mcu_pkg;

  // byte address
  typedef logic [31:0] bus_addr_t;

  // data word
  typedef logic [31:0] bus_data_t;

  // one enable per byte lane
  typedef logic [3:0] bus_be_t;

  // word index within one ram bank
  typedef logic [7:0] ram_idx_t;

  typedef logic [1:0] slave_sel_t;

  localparam slave_sel_t SEL_RAM0   = 2'd0;
  localparam slave_sel_t SEL_RAM1   = 2'd1;
  localparam slave_sel_t SEL_PERIPH = 2'd2;
  localparam slave_sel_t SEL_NONE   = 2'd3;

endpackage

/* common/mini_mcu_cfg.svh */
////////////////////
// memory map, ram depth and bus error value
////////////////////
`ifndef MINI_MCU_CFG_SVH
`define MINI_MCU_CFG_SVH

// ram banks, 1 KB each
`define RAM0_BASE 32'h0000_0000
`define RAM1_BASE 32'h0000_0400
`define RAM_WORDS 256

// peripheral space, 8 KB
`define PERIPH_BASE 32'h2000_0000
`define PERIPH_SIZE 32'h0000_2000
`define SOC_CTRL_OFFSET 32'h0000
`define GPIO_OFFSET 32'h1000

// read data for unmapped addresses
`define BUS_ERR_RDATA 32'hBADC_AB1E

`endif
